/* bench/ddr_read_model.sv */
/*
  AXI read slave standing in for the DDR3 controller
  answers every AR with a 24 beat burst of 8 byte beats, the byte at
  address a is a[7:0] ^ a[15:8], arready and rvalid gaps are random
  outputs change 1 ns after the rising clock edge
*/
`include "layer_params.svh"
`default_nettype none

module ddr_read_model
	import axi_rd_pkg::*;
#(
	parameter int SEED = 0
) (
	input  wire          clk,
	input  wire          reset_n,
	input  wire axi_ar_t ar,
	input  wire          arvalid,
	output logic         arready,
	output axi_r_t       r,
	output logic         rvalid,
	input  wire          rready
);
	timeunit 1ns;
	timeprecision 100ps;

	integer             seed;
	logic               busy;
	logic [`ADDR_W-1:0] addr;
	int                 beat;
	// handshakes as seen at the clock edge
	logic               ar_hs;
	logic               r_hs;
	logic               in_reset;

	// one little-endian beat starting at byte address a
	function automatic logic [`BEAT_W-1:0] beat_word(input logic [`ADDR_W-1:0] a);
		logic [`BEAT_W-1:0] w;
		logic [`ADDR_W-1:0] ab;
		int                 b;
		for (b = 0; b < 8; b++) begin
			ab = a + b;
			w[8*b +: 8] = ab[7:0] ^ ab[15:8];
		end
		return w;
	endfunction

	initial begin
		seed = SEED;
		arready = 1'b0;
		rvalid = 1'b0;
		r = '0;
		busy = 1'b0;
		addr = '0;
		beat = 0;
	end

	always @(posedge clk) begin
		in_reset = !reset_n;
		ar_hs = arvalid && arready;
		r_hs = rvalid && rready;
		#1;
		if (in_reset) begin
			busy = 1'b0;
			arready = 1'b0;
			rvalid = 1'b0;
		end else begin
			if (ar_hs) begin
				busy = 1'b1;
				addr = ar.araddr;
				beat = 0;
			end
			if (r_hs) begin
				beat++;
				if (beat == `BEATS_PER_BAND)
					busy = 1'b0;
			end
			// one burst in flight at a time, an idle slave still stalls at random
			arready = !busy && (($random(seed) & 1) != 0);
			// a raised beat waits for rready, otherwise roll for a gap
			if (!busy)
				rvalid = 1'b0;
			else if (!rvalid || r_hs)
				rvalid = ($random(seed) & 3) != 0;
			r.rdata = beat_word(addr + beat * 8);
			r.rlast = (beat == `BEATS_PER_BAND - 1);
		end
	end

endmodule

`default_nettype wire

/* bench/tb_input_layer.sv */
/*
  testbench for the input layer streamer
  runs two passes against the DDR read model with random win_ready,
  expected bursts and windows come from the byte rule and band order,
  the assertions at the bottom do the checking
*/
`include "layer_params.svh"
`default_nettype none

module tb_input_layer
	import axi_rd_pkg::*;
	import layer_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	logic               clk = 1'b0;
	logic               reset_n = 1'b0;
	layer_cfg_t         cfg = '0;
	logic               ddr_data_rdy = 1'b0;
	logic               win_ready = 1'b0;
	axi_ar_t            ar;
	logic               arvalid;
	logic               arready;
	axi_r_t             r;
	logic               rvalid;
	logic               rready;
	window_data_t       win_data;
	window_pos_t        win_pos;
	logic               win_valid;
	integer             seed = 32'hfe3816ef;
	int                 errors = 0;
	// expected bursts and windows, both passes appended
	logic [`ADDR_W-1:0] addr_ref [0:15];
	window_pos_t        pos_ref [0:511];
	window_data_t       data_ref [0:511];
	int                 addr_total = 0;
	int                 win_total = 0;
	int                 ar_idx = 0;
	int                 win_idx = 0;
	logic [`ADDR_W-1:0] addr_exp;
	window_pos_t        pos_exp;
	window_data_t       data_exp;
	logic               rst_q = 1'b0;
	logic               seen_reset = 1'b0;
	logic               expect_idle = 1'b0;

	input_layer_streamer uut (
		.clk(clk), .reset_n(reset_n), .cfg(cfg), .ddr_data_rdy(ddr_data_rdy),
		.ar(ar), .arvalid(arvalid), .arready(arready),
		.r(r), .rvalid(rvalid), .rready(rready),
		.win_data(win_data), .win_pos(win_pos),
		.win_valid(win_valid), .win_ready(win_ready)
	);

	ddr_read_model #(.SEED(32'hfe3816ef)) u_ddr (
		.clk(clk), .reset_n(reset_n), .ar(ar), .arvalid(arvalid), .arready(arready),
		.r(r), .rvalid(rvalid), .rready(rready)
	);

	always #2 clk = ~clk;

	// consumer back-pressure, ready about three cycles in four
	always @(posedge clk) begin
		#1;
		win_ready = ($random(seed) & 3) != 0;
	end

	assign addr_exp = addr_ref[ar_idx];
	assign pos_exp = pos_ref[win_idx];
	assign data_exp = data_ref[win_idx];

	// transfer counters point at the next expected entry
	always @(posedge clk) begin
		rst_q <= reset_n;
		if (!reset_n) begin
			seen_reset <= 1'b1;
			ar_idx <= 0;
			win_idx <= 0;
		end else begin
			if (arvalid && arready)
				ar_idx <= ar_idx + 1;
			if (win_valid && win_ready)
				win_idx <= win_idx + 1;
		end
	end

	// ddr byte of one pixel, base_addr 0, 4 KB per layer, 64 bytes per row
	function automatic logic [7:0] pixel_at(input int lay, input int row, input int col);
		int a;
		a = lay * 4096 + row * 64 + col;
		return a[7:0] ^ a[15:8];
	endfunction

	//------------------------------
	// reference lists, row outer and layer inner
	task automatic add_pass(input int layers, input int rows, input int cols);
		window_data_t w;
		for (int row = 0; row <= rows - 3; row++) begin
			for (int lay = 0; lay < layers; lay++) begin
				addr_ref[addr_total] = lay * 4096 + row * 64;
				addr_total++;
				for (int col = 0; col <= cols - 3; col++) begin
					for (int i = 0; i < 3; i++) begin
						for (int j = 0; j < 3; j++)
							w[i][j] = pixel_at(lay, row + i, col + j);
					end
					pos_ref[win_total].layer = `DIM_W'(lay);
					pos_ref[win_total].row = `DIM_W'(row);
					pos_ref[win_total].col = `DIM_W'(col);
					data_ref[win_total] = w;
					win_total++;
				end
			end
		end
	endtask

	// one pass from the ddr_data_rdy edge to a quiet stream
	task automatic run_pass(input int layers, input int rows, input int cols, output bit ok);
		int err0;
		int n;
		err0 = errors;
		expect_idle = 1'b0;
		ddr_data_rdy = 1'b0;
		cfg.base_addr = '0;
		cfg.no_of_layers = `DIM_W'(layers);
		cfg.row_size = `DIM_W'(rows);
		cfg.col_size = `DIM_W'(cols);
		add_pass(layers, rows, cols);
		@(posedge clk);
		#1;
		ddr_data_rdy = 1'b1;
		n = 0;
		while (win_idx < win_total && n < 20000) begin
			@(posedge clk);
			#1;
			n++;
		end
		ok = (win_idx >= win_total);
		if (!ok) begin
			errors++;
			$display("timeout: %0d of %0d windows after %0d cycles", win_idx, win_total, n);
		end else begin
			// the stream has to stay quiet after its last window
			expect_idle = 1'b1;
			for (n = 0; n < 50; n++) begin
				@(posedge clk);
				#1;
			end
			assert (ar_idx == addr_total) else begin
				errors++;
				$display("MISMATCH burst_count exp %h got %h", addr_total, ar_idx);
			end
			assert (win_idx == win_total) else begin
				errors++;
				$display("MISMATCH window_count exp %h got %h", win_total, win_idx);
			end
		end
		$display("pass %0d layers %0d rows %0d cols: %0d windows, %0d bursts, %0d errors",
			layers, rows, cols, win_idx, ar_idx, errors - err0);
	endtask

	initial begin
		bit ok;
		ok = 1'b1;
		repeat (8) @(posedge clk);
		#1;
		reset_n = 1'b1;
		@(posedge clk);
		#1;
		$display("reset: outputs quiet, %0d errors", errors);
		run_pass(2, 5, 12, ok);
		if (ok)
			run_pass(3, 4, 64, ok);
		$display("summary: %0d windows, %0d bursts, %0d errors", win_idx, ar_idx, errors);
		if (ok && errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	//------------------------------
	// checks
	a_reset_quiet: assert property (@(posedge clk)
		(seen_reset && (!reset_n || !rst_q)) |-> (!arvalid && !rready && !win_valid))
		else begin
			errors++;
			$display("arvalid, rready or win_valid high during reset or right after it");
		end

	a_ar_addr: assert property (@(posedge clk) disable iff (!reset_n)
		(arvalid && arready) |-> (ar.araddr == addr_exp))
		else begin
			errors++;
			$display("MISMATCH araddr exp %h got %h", $sampled(addr_exp), $sampled(ar.araddr));
		end

	a_ar_hold: assert property (@(posedge clk) disable iff (!reset_n)
		(arvalid && !arready) |=> (arvalid && $stable(ar)))
		else begin
			errors++;
			$display("arvalid dropped or ar changed before arready");
		end

	a_win_pos: assert property (@(posedge clk) disable iff (!reset_n)
		(win_valid && win_ready) |-> (win_pos == pos_exp))
		else begin
			errors++;
			$display("MISMATCH win_pos exp %h got %h", $sampled(pos_exp), $sampled(win_pos));
		end

	a_win_data: assert property (@(posedge clk) disable iff (!reset_n)
		(win_valid && win_ready) |-> (win_data == data_exp))
		else begin
			errors++;
			$display("MISMATCH win_data exp %h got %h", $sampled(data_exp), $sampled(win_data));
		end

	// a stalled window keeps its payload
	a_win_hold: assert property (@(posedge clk) disable iff (!reset_n)
		(win_valid && !win_ready) |=> (win_valid && $stable(win_data) && $stable(win_pos)))
		else begin
			errors++;
			$display("window dropped or changed while stalled");
		end

	a_win_extra: assert property (@(posedge clk) disable iff (!reset_n)
		(win_valid && win_ready) |-> (win_idx < win_total))
		else begin
			errors++;
			$display("window transferred beyond the expected count");
		end

	a_idle: assert property (@(posedge clk) disable iff (!reset_n)
		expect_idle |-> (!win_valid && !arvalid))
		else begin
			errors++;
			$display("window or burst issued after the last window of the pass");
		end

endmodule

`default_nettype wire

/* list.f */
+incdir+src
src/axi_rd_pkg.sv
src/layer_pkg.sv
src/band_sequencer.sv
src/band_fetcher.sv
src/row_buffer.sv
src/window_shifter.sv
src/input_layer_streamer.sv
bench/ddr_read_model.sv
bench/tb_input_layer.sv

/* src/axi_rd_pkg.sv */
/*
  AXI read channel payloads used by the band fetcher
  only the fields that change per burst travel here, the memory side
  assumes fixed 24 beat incrementing bursts of 8 byte beats
*/
`include "layer_params.svh"
`default_nettype none

package axi_rd_pkg;

	// read address channel payload
	typedef struct packed {
		logic [`ADDR_W-1:0] araddr;
	} axi_ar_t;

	// read data channel payload
	// rresp is not looked at
	typedef struct packed {
		logic [`BEAT_W-1:0] rdata;
		logic               rlast;
	} axi_r_t;

endpackage

`default_nettype wire

/* src/band_fetcher.sv */
/*
  AXI read master, one 24 beat burst per band
  the sequencer supplies the address on ar, this block runs the
  handshakes and writes every beat straight into the band's bank
*/
`include "layer_params.svh"
`default_nettype none

module band_fetcher
	import axi_rd_pkg::*;
	import layer_pkg::*;
(
	input  wire                     clk,
	input  wire                     reset_n,
	input  wire                     fetch_req,
	input  wire band_t              fetch_band,
	output logic                    fetch_done,
	output logic                    arvalid,
	input  wire                     arready,
	input  wire                     rvalid,
	output logic                    rready,
	input  wire axi_r_t             r,
	output logic                    we,
	output logic [`BUF_ADDR_W-1:0]  waddr,
	output logic [`BEAT_W-1:0]      wdata
);

	typedef enum logic [1:0] {ST_IDLE, ST_ADDR, ST_DATA} state_t;

	state_t                  state;
	logic                    bank;
	// word index inside the bank, beat k goes to word k
	logic [`BUF_ADDR_W-2:0]  beat;

	assign arvalid = (state == ST_ADDR);
	assign rready = (state == ST_DATA);
	assign we = rvalid && rready;
	assign waddr = {bank, beat};
	assign wdata = r.rdata;
	assign fetch_done = we && r.rlast;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: if (fetch_req) state <= ST_ADDR;
				ST_ADDR: if (arready) state <= ST_DATA;
				ST_DATA: if (fetch_done) state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_req)
			bank <= fetch_band.bank;
		if (arvalid && arready)
			beat <= '0;
		else if (we)
			beat <= beat + 1'b1;
	end

	// slave ends the burst on beat 24 and nowhere else
	a_rlast_beat: assert property (@(posedge clk) disable iff (!reset_n)
		we |-> (r.rlast == (beat == (`BUF_ADDR_W-1)'(`BEATS_PER_BAND - 1))));

	// sequencer waits for fetch_done before the next band
	a_req_idle: assert property (@(posedge clk) disable iff (!reset_n)
		fetch_req |-> (state == ST_IDLE));

endmodule

`default_nettype wire

/* src/band_sequencer.sv */
/*
  walks the bands of a pass, output row outer and layer inner
  a fetch cursor hands bands to the fetcher, a drain cursor to the shifter
  one full bit per bank keeps the fetcher out of a bank still being drained
*/
`include "layer_params.svh"
`default_nettype none

module band_sequencer
	import axi_rd_pkg::*;
	import layer_pkg::*;
(
	input  wire             clk,
	input  wire             reset_n,
	input  wire layer_cfg_t cfg,
	input  wire             ddr_data_rdy,
	output logic            fetch_req,
	output band_t           fetch_band,
	input  wire             fetch_done,
	output logic            drain_req,
	output band_t           drain_band,
	input  wire             drain_done,
	output axi_ar_t         ar
);

	logic       rdy_q;
	logic       active;
	logic       start;
	// fetch side
	logic       f_more;
	logic       f_busy;
	// drain side
	logic       d_busy;
	// bank holds a band not yet drained
	logic [1:0] full;

	function automatic band_t next_band(band_t b);
		band_t n;
		n = b;
		n.bank = ~b.bank;
		if (b.layer == cfg.no_of_layers - 1'b1) begin
			n.layer = '0;
			n.row = b.row + 1'b1;
		end else begin
			n.layer = b.layer + 1'b1;
		end
		return n;
	endfunction

	function automatic logic last_band(band_t b);
		return (b.row == cfg.row_size - 2'd3) && (b.layer == cfg.no_of_layers - 1'b1);
	endfunction

	// rising edge of ddr_data_rdy, ignored mid pass
	assign start = ddr_data_rdy && !rdy_q && !active;

	assign fetch_req = active && f_more && !f_busy && !full[fetch_band.bank];
	assign drain_req = active && !d_busy && full[drain_band.bank];

	// cursor only moves on fetch_done so the address holds for the whole burst
	assign ar.araddr = cfg.base_addr
		+ (`ADDR_W'(fetch_band.layer) << `LAYER_SHIFT)
		+ (`ADDR_W'(fetch_band.row) << `ROW_SHIFT);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			rdy_q <= 1'b0;
			active <= 1'b0;
			f_more <= 1'b0;
			f_busy <= 1'b0;
			d_busy <= 1'b0;
			full <= 2'b00;
			fetch_band <= '0;
			drain_band <= '0;
		end else begin
			rdy_q <= ddr_data_rdy;
			if (start) begin
				active <= 1'b1;
				f_more <= 1'b1;
				full <= 2'b00;
				fetch_band <= '0;
				drain_band <= '0;
			end
			//------------------------------
			// fetch cursor
			if (fetch_req)
				f_busy <= 1'b1;
			if (fetch_done) begin
				f_busy <= 1'b0;
				full[fetch_band.bank] <= 1'b1;
				fetch_band <= next_band(fetch_band);
				if (last_band(fetch_band))
					f_more <= 1'b0;
			end
			//------------------------------
			// drain cursor, last drain ends the pass
			if (drain_req)
				d_busy <= 1'b1;
			if (drain_done) begin
				d_busy <= 1'b0;
				full[drain_band.bank] <= 1'b0;
				drain_band <= next_band(drain_band);
				if (last_band(drain_band))
					active <= 1'b0;
			end
		end
	end

	// fetcher and shifter never share a bank while both are at work
	a_bank_owner: assert property (@(posedge clk) disable iff (!reset_n)
		(f_busy && d_busy) |-> (fetch_band.bank != drain_band.bank));

endmodule

`default_nettype wire

/* src/input_layer_streamer.sv */
/*
  top of the input layer streamer
  reads 3-row bands of CNN input layers from DDR3 over AXI read and
  streams 3x3 windows with their layer, row and column position
  start a pass with a rising edge on ddr_data_rdy
*/
`include "layer_params.svh"
`default_nettype none

module input_layer_streamer
	import axi_rd_pkg::*;
	import layer_pkg::*;
(
	input  wire             clk,
	input  wire             reset_n,
	input  wire layer_cfg_t cfg,
	input  wire             ddr_data_rdy,
	output axi_ar_t         ar,
	output logic            arvalid,
	input  wire             arready,
	input  wire axi_r_t     r,
	input  wire             rvalid,
	output logic            rready,
	output window_data_t    win_data,
	output window_pos_t     win_pos,
	output logic            win_valid,
	input  wire             win_ready
);

	logic                    fetch_req;
	logic                    fetch_done;
	logic                    drain_req;
	logic                    drain_done;
	band_t                   fetch_band;
	band_t                   drain_band;
	// row buffer write side
	logic                    we;
	logic [`BUF_ADDR_W-1:0]  waddr;
	logic [`BEAT_W-1:0]      wdata;
	// row buffer read side, one port per window row
	logic [`BUF_ADDR_W-1:0]  raddr0;
	logic [`BUF_ADDR_W-1:0]  raddr1;
	logic [`BUF_ADDR_W-1:0]  raddr2;
	logic [`BEAT_W-1:0]      rdata0;
	logic [`BEAT_W-1:0]      rdata1;
	logic [`BEAT_W-1:0]      rdata2;

	band_sequencer u_seq (
		.clk(clk), .reset_n(reset_n), .cfg(cfg), .ddr_data_rdy(ddr_data_rdy),
		.fetch_req(fetch_req), .fetch_band(fetch_band), .fetch_done(fetch_done),
		.drain_req(drain_req), .drain_band(drain_band), .drain_done(drain_done),
		.ar(ar)
	);

	band_fetcher u_fetch (
		.clk(clk), .reset_n(reset_n),
		.fetch_req(fetch_req), .fetch_band(fetch_band), .fetch_done(fetch_done),
		.arvalid(arvalid), .arready(arready),
		.rvalid(rvalid), .rready(rready), .r(r),
		.we(we), .waddr(waddr), .wdata(wdata)
	);

	row_buffer u_buf (
		.clk(clk), .we(we), .waddr(waddr), .wdata(wdata),
		.raddr0(raddr0), .raddr1(raddr1), .raddr2(raddr2),
		.rdata0(rdata0), .rdata1(rdata1), .rdata2(rdata2)
	);

	window_shifter u_shift (
		.clk(clk), .reset_n(reset_n), .cfg(cfg),
		.drain_req(drain_req), .drain_band(drain_band), .drain_done(drain_done),
		.raddr0(raddr0), .raddr1(raddr1), .raddr2(raddr2),
		.rdata0(rdata0), .rdata1(rdata1), .rdata2(rdata2),
		.win_data(win_data), .win_pos(win_pos),
		.win_valid(win_valid), .win_ready(win_ready)
	);

	// address comes from the sequencer, the handshake from the fetcher
	a_ar_hold: assert property (@(posedge clk) disable iff (!reset_n)
		(arvalid && !arready) |=> (arvalid && $stable(ar)));

endmodule

`default_nettype wire

/* src/layer_params.svh */
/*
  shared widths, strides and burst size of the input layer streamer
  include ahead of the packages and modules that size their ports on them
*/
`ifndef LAYER_PARAMS_SVH
`define LAYER_PARAMS_SVH

// ddr side
`define ADDR_W 32
`define BEAT_W 64
// layer geometry, one 64 byte row is eight beats
`define DIM_W 10
`define BEATS_PER_ROW 8
`define WIN_ROWS 3
`define BEATS_PER_BAND 24
// ddr strides as shifts, layers sit on 4k boundaries
`define ROW_SHIFT 6
`define LAYER_SHIFT 12
// row buffer address, bank bit on top of a 5 bit word index
`define BUF_ADDR_W 6

`endif

/* src/layer_pkg.sv */
/*
  types that describe the input layers and the windows cut from them
  layer_cfg_t is held stable by the host for a whole pass
*/
`include "layer_params.svh"
`default_nettype none

package layer_pkg;

	// row_size >= 3, col_size in 3..64
	typedef struct packed {
		logic [`ADDR_W-1:0] base_addr;
		logic [`DIM_W-1:0]  no_of_layers;
		logic [`DIM_W-1:0]  row_size;
		logic [`DIM_W-1:0]  col_size;
	} layer_cfg_t;

	// top left pixel of a window
	typedef struct packed {
		logic [`DIM_W-1:0] layer;
		logic [`DIM_W-1:0] row;
		logic [`DIM_W-1:0] col;
	} window_pos_t;

	// pixel [0][0] lands in the most significant byte
	typedef logic [0:`WIN_ROWS-1][0:`WIN_ROWS-1][7:0] window_data_t;

	// one band of three rows and the row buffer bank it lives in
	typedef struct packed {
		logic [`DIM_W-1:0] layer;
		logic [`DIM_W-1:0] row;
		logic              bank;
	} band_t;

endpackage

`default_nettype wire

/* src/row_buffer.sv */
/*
  ping-pong band storage, two banks of 32 words of 64 bits
  one write port fed by the fetcher, three read ports for the three
  window rows, read data is registered and lags the address by a cycle
*/
`include "layer_params.svh"
`default_nettype none

module row_buffer (
	input  wire                     clk,
	input  wire                     we,
	input  wire [`BUF_ADDR_W-1:0]   waddr,
	input  wire [`BEAT_W-1:0]       wdata,
	input  wire [`BUF_ADDR_W-1:0]   raddr0,
	input  wire [`BUF_ADDR_W-1:0]   raddr1,
	input  wire [`BUF_ADDR_W-1:0]   raddr2,
	output logic [`BEAT_W-1:0]      rdata0,
	output logic [`BEAT_W-1:0]      rdata1,
	output logic [`BEAT_W-1:0]      rdata2
);

	// bank select is the top address bit
	logic [`BEAT_W-1:0] mem [0:(1 << `BUF_ADDR_W)-1];

	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
	end

	// one port per window row
	always_ff @(posedge clk) begin
		rdata0 <= mem[raddr0];
		rdata1 <= mem[raddr1];
		rdata2 <= mem[raddr2];
	end

endmodule

`default_nettype wire

/* src/window_shifter.sv */
/*
  slides a 3x3 window along one band held in the row buffer
  each row keeps two neighbouring words, 16 bytes, the window takes
  three bytes from there, on a word boundary the next word shifts in
  raddr always points two words ahead so that word is ready in time
*/
`include "layer_params.svh"
`default_nettype none

module window_shifter
	import layer_pkg::*;
(
	input  wire                     clk,
	input  wire                     reset_n,
	input  wire layer_cfg_t         cfg,
	input  wire                     drain_req,
	input  wire band_t              drain_band,
	output logic                    drain_done,
	output logic [`BUF_ADDR_W-1:0]  raddr0,
	output logic [`BUF_ADDR_W-1:0]  raddr1,
	output logic [`BUF_ADDR_W-1:0]  raddr2,
	input  wire [`BEAT_W-1:0]       rdata0,
	input  wire [`BEAT_W-1:0]       rdata1,
	input  wire [`BEAT_W-1:0]       rdata2,
	output window_data_t            win_data,
	output window_pos_t             win_pos,
	output logic                    win_valid,
	input  wire                     win_ready
);

	// load0 puts word 0 on the bus, load1 and load2 take words 0 and 1
	typedef enum logic [2:0] {ST_IDLE, ST_LOAD0, ST_LOAD1, ST_LOAD2, ST_RUN} state_t;

	state_t                                   state;
	band_t                                    band_q;
	logic [`DIM_W-1:0]                        col;
	// word index being read, two ahead of the low held word once running
	logic [3:0]                               widx;
	logic [`WIN_ROWS-1:0][2*`BEAT_W-1:0]      hold;
	logic [`WIN_ROWS-1:0][`BEAT_W-1:0]        rdata;
	logic [`WIN_ROWS-1:0][`BUF_ADDR_W-1:0]    raddr;
	logic [2:0]                               off;
	logic                                     xfer;
	logic                                     last_col;
	logic                                     run_shift;
	logic                                     shift;
	logic                                     step;

	assign rdata = {rdata2, rdata1, rdata0};
	assign raddr0 = raddr[0];
	assign raddr1 = raddr[1];
	assign raddr2 = raddr[2];

	assign win_valid = (state == ST_RUN);
	assign xfer = win_valid && win_ready;
	// byte offset of column c inside the low held word
	assign off = col[2:0];
	assign last_col = (col == cfg.col_size - 2'd3);
	assign run_shift = xfer && (off == 3'd7) && !last_col;
	assign shift = (state == ST_LOAD1) || (state == ST_LOAD2) || run_shift;
	assign step = (state == ST_LOAD0) || (state == ST_LOAD1) || run_shift;

	assign win_pos.layer = band_q.layer;
	assign win_pos.row = band_q.row;
	assign win_pos.col = col;

	always_comb begin
		for (int i = 0; i < `WIN_ROWS; i++) begin
			// band row i starts at word 8i of its bank
			raddr[i] = {band_q.bank, (`BUF_ADDR_W-1)'(i * `BEATS_PER_ROW + widx)};
			for (int j = 0; j < `WIN_ROWS; j++)
				win_data[i][j] = hold[i][(off + j) * 8 +: 8];
		end
	end

	//------------------------------
	// control
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= ST_IDLE;
			drain_done <= 1'b0;
		end else begin
			drain_done <= xfer && last_col;
			case (state)
				ST_IDLE: if (drain_req) state <= ST_LOAD0;
				ST_LOAD0: state <= ST_LOAD1;
				ST_LOAD1: state <= ST_LOAD2;
				ST_LOAD2: state <= ST_RUN;
				ST_RUN: if (xfer && last_col) state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	//------------------------------
	// band position and byte window
	always_ff @(posedge clk) begin
		if (drain_req) begin
			band_q <= drain_band;
			col <= '0;
			widx <= '0;
		end else begin
			if (xfer && !last_col)
				col <= col + 1'b1;
			if (step)
				widx <= widx + 1'b1;
		end
		// new word enters at the top, low word drops out
		if (shift) begin
			for (int i = 0; i < `WIN_ROWS; i++)
				hold[i] <= {rdata[i], hold[i][2*`BEAT_W-1:`BEAT_W]};
		end
	end

	// a stalled window stays put until the consumer takes it
	a_win_stable: assert property (@(posedge clk) disable iff (!reset_n)
		(win_valid && !win_ready) |=> (win_valid && $stable(win_data) && $stable(win_pos)));

endmodule

`default_nettype wire
